//--- common/ps2_pkg.sv
// Shared PS/2 receive types and constants, imported by every keyboard RTL block
package ps2_pkg;

  // ------------------------------------------------------------
  // Frame format and receiver timing
  // ------------------------------------------------------------

  // Start, eight data bits, odd parity, stop
  localparam int FRAME_BITS = 11;

  // Bit counter must reach FRAME_BITS itself
  localparam int BIT_COUNT_W = $clog2(FRAME_BITS + 1);

  // About 60 us of clk while the PS/2 clock idles mid-frame
  localparam int RX_TIMEOUT_CYCLES = 2950;
  localparam int RX_TIMEOUT_W      = 12;  // Holds RX_TIMEOUT_CYCLES - 1

  // ------------------------------------------------------------
  // Special set 2 scan codes
  // ------------------------------------------------------------

  localparam logic [7:0] SCAN_RELEASE     = 8'hF0;  // Break prefix
  localparam logic [7:0] SCAN_LEFT_SHIFT  = 8'h12;
  localparam logic [7:0] SCAN_RIGHT_SHIFT = 8'h59;

  // '.' for codes outside the table
  localparam logic [7:0] ASCII_UNKNOWN = 8'h2E;

  // ------------------------------------------------------------
  // Frame word
  // ------------------------------------------------------------

  // Field view, LSB is the first bit on the wire
  typedef struct packed {
    logic       stop;    // Always 1 on a good frame
    logic       parity;  // Odd over data
    logic [7:0] data;    // Scan code byte
    logic       start;   // Always 0 on a good frame
  } ps2_frame_fields_t;

  // Shift register fills raw, decoder reads fields
  typedef union packed {
    logic [FRAME_BITS-1:0] raw;
    ps2_frame_fields_t     fields;
  } ps2_frame_t;

  // ------------------------------------------------------------
  // Key event handed to the host
  // ------------------------------------------------------------

  typedef struct packed {
    logic       released;   // Break code seen before this scan code
    logic       shift_on;   // Either shift key held
    logic [7:0] scan_code;  // Raw set 2 code
    logic [7:0] ascii;      // Translated character
  } key_event_t;

endpackage

//--- hw/ps2_rx_frame/ps2_rx_frame.sv
// PS/2 line receiver; syncs clock and data, shifts in device-to-host frames, flags each one
`timescale 1ns/1ns

module ps2_rx_frame
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk_i,     // Keyboard clock, idles high
  input  logic       ps2_data_i,    // Keyboard data, idles high
  output ps2_frame_t frame_o,       // Last complete frame
  output logic       frame_done_o   // One clk pulse per frame
);

  logic [1:0]              clk_sync_q;   // [1] is the usable copy
  logic [1:0]              data_sync_q;
  logic                    clk_prev_q;   // Synced clock, one cycle late
  logic                    clk_fall;
  ps2_frame_t              frame_q;
  logic [BIT_COUNT_W-1:0]  bit_cnt_q;
  logic                    frame_full;
  logic [RX_TIMEOUT_W-1:0] wd_cnt_q;
  logic                    wd_expired;
  logic                    frame_done_q;

  // ------------------------------------------------------------
  // Input synchronizers and edge detect
  // ------------------------------------------------------------

  // Preset high so reset release does not fake a falling edge
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_sync_q  <= 2'b11;
      data_sync_q <= 2'b11;
      clk_prev_q  <= 1'b1;
    end
    else
    begin
      clk_sync_q  <= {clk_sync_q[0], ps2_clk_i};
      data_sync_q <= {data_sync_q[0], ps2_data_i};
      clk_prev_q  <= clk_sync_q[1];
    end
  end

  assign clk_fall = clk_prev_q & ~clk_sync_q[1];  // High for one cycle

  // ------------------------------------------------------------
  // Frame shift register and bit counter
  // ------------------------------------------------------------

  // LSB first, so the start bit ends up in bit 0
  always_ff @(posedge clk)
  begin
    if (clk_fall)
      frame_q.raw <= {data_sync_q[1], frame_q.raw[FRAME_BITS-1:1]};
  end

  assign frame_full = (bit_cnt_q == BIT_COUNT_W'(FRAME_BITS));

  always_ff @(posedge clk)
  begin
    if (reset)
      bit_cnt_q <= '0;
    else if (frame_full)
      bit_cnt_q <= '0;                     // Frame handed off
    else if (wd_expired)
      bit_cnt_q <= '0;                     // Keyboard stalled mid-frame
    else if (clk_fall)
      bit_cnt_q <= bit_cnt_q + 1'b1;
  end

  // Done one cycle after the 11th bit lands
  always_ff @(posedge clk)
  begin
    if (reset)
      frame_done_q <= 1'b0;
    else
      frame_done_q <= frame_full;
  end

  // ------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------

  // Runs only while clock idles high inside a partial frame
  always_ff @(posedge clk)
  begin
    if (reset || !clk_sync_q[1] || (bit_cnt_q == '0))
      wd_cnt_q <= '0;
    else if (!wd_expired)
      wd_cnt_q <= wd_cnt_q + 1'b1;         // Saturates at expiry
  end

  assign wd_expired = (wd_cnt_q == RX_TIMEOUT_W'(RX_TIMEOUT_CYCLES - 1));

  assign frame_o      = frame_q;           // Held until the next falling edge
  assign frame_done_o = frame_done_q;

endmodule

//--- hw/ps2_ascii_map.sv
// Set 2 scan code to ASCII lookup; letters follow shift, all else ignores it
`timescale 1ns/1ns

module ps2_ascii_map
  import ps2_pkg::*;
(
  input  logic [7:0] scan_code_i,
  input  logic       shift_on_i,
  output logic [7:0] ascii_o
);

  logic [7:0] base_char;  // Unshifted character
  logic       is_letter;  // Only letters change case

  always_comb
  begin
    is_letter = 1'b1;
    case (scan_code_i)
      // Letters, lower case
      8'h1C: base_char = 8'h61;  // a
      8'h32: base_char = 8'h62;  // b
      8'h21: base_char = 8'h63;  // c
      8'h23: base_char = 8'h64;  // d
      8'h24: base_char = 8'h65;  // e
      8'h2B: base_char = 8'h66;  // f
      8'h34: base_char = 8'h67;  // g
      8'h33: base_char = 8'h68;  // h
      8'h43: base_char = 8'h69;  // i
      8'h3B: base_char = 8'h6A;  // j
      8'h42: base_char = 8'h6B;  // k
      8'h4B: base_char = 8'h6C;  // l
      8'h3A: base_char = 8'h6D;  // m
      8'h31: base_char = 8'h6E;  // n
      8'h44: base_char = 8'h6F;  // o
      8'h4D: base_char = 8'h70;  // p
      8'h15: base_char = 8'h71;  // q
      8'h2D: base_char = 8'h72;  // r
      8'h1B: base_char = 8'h73;  // s
      8'h2C: base_char = 8'h74;  // t
      8'h3C: base_char = 8'h75;  // u
      8'h2A: base_char = 8'h76;  // v
      8'h1D: base_char = 8'h77;  // w
      8'h22: base_char = 8'h78;  // x
      8'h35: base_char = 8'h79;  // y
      8'h1A: base_char = 8'h7A;  // z
      default:
      begin
        is_letter = 1'b0;
        case (scan_code_i)
          // Top row digits
          8'h45: base_char = 8'h30;  // 0
          8'h16: base_char = 8'h31;  // 1
          8'h1E: base_char = 8'h32;  // 2
          8'h26: base_char = 8'h33;  // 3
          8'h25: base_char = 8'h34;  // 4
          8'h2E: base_char = 8'h35;  // 5
          8'h36: base_char = 8'h36;  // 6
          8'h3D: base_char = 8'h37;  // 7
          8'h3E: base_char = 8'h38;  // 8
          8'h46: base_char = 8'h39;  // 9
          // Whitespace and control keys
          8'h29: base_char = 8'h20;  // Space
          8'h5A: base_char = 8'h0D;  // Enter
          8'h66: base_char = 8'h08;  // Backspace
          8'h76: base_char = 8'h1B;  // Esc
          default: base_char = ASCII_UNKNOWN;
        endcase
      end
    endcase
  end

  // Upper case is lower case with bit 5 cleared
  assign ascii_o = (shift_on_i && is_letter) ? (base_char & 8'hDF) : base_char;

endmodule

//--- hw/ps2_key_decode.sv
// Key event builder; tracks break prefix and shift keys, holds one event for the host
`timescale 1ns/1ns

module ps2_key_decode
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  ps2_frame_t frame_i,
  input  logic       frame_done_i,
  input  logic       read_i,       // Host takes the event
  input  logic [7:0] ascii_i,      // From the ASCII table
  output logic [7:0] scan_code_o,  // To the ASCII table
  output logic       shift_on_o,   // Shift state before this frame
  output key_event_t event_o,
  output logic       ready_o
);

  typedef enum logic {
    RDY_IDLE = 1'b0,
    RDY_HOLD = 1'b1
  } ready_state_e;

  ready_state_e state_q;
  ready_state_e state_d;
  logic         frame_ok;
  logic         is_release;
  logic         store_event;
  logic         release_hold_q;  // F0 seen, waiting for the key code
  logic         left_shift_q;
  logic         right_shift_q;
  key_event_t   event_q;

  // Start 0, stop 1, odd parity
  assign frame_ok = ~frame_i.fields.start & frame_i.fields.stop &
                    (frame_i.fields.parity == ~^frame_i.fields.data);

  assign is_release  = (frame_i.fields.data == SCAN_RELEASE);
  assign store_event = frame_done_i & frame_ok & ~is_release;

  assign scan_code_o = frame_i.fields.data;
  assign shift_on_o  = left_shift_q | right_shift_q;

  // ------------------------------------------------------------
  // Prefix and shift tracking
  // ------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      release_hold_q <= 1'b0;
    else if (frame_done_i && frame_ok)
      release_hold_q <= is_release;        // Any key code consumes it
  end

  // Make sets the key, break clears it
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift_q  <= 1'b0;
      right_shift_q <= 1'b0;
    end
    else if (store_event)
    begin
      if (frame_i.fields.data == SCAN_LEFT_SHIFT)
        left_shift_q <= ~release_hold_q;
      if (frame_i.fields.data == SCAN_RIGHT_SHIFT)
        right_shift_q <= ~release_hold_q;
    end
  end

  // Overwrites even when the host has not read yet
  always_ff @(posedge clk)
  begin
    if (reset)
      event_q <= '0;
    else if (store_event)
    begin
      event_q.released  <= release_hold_q;
      event_q.shift_on  <= shift_on_o;
      event_q.scan_code <= frame_i.fields.data;
      event_q.ascii     <= ascii_i;
    end
  end

  // ------------------------------------------------------------
  // Ready handshake
  // ------------------------------------------------------------

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      RDY_IDLE: if (store_event) state_d = RDY_HOLD;
      RDY_HOLD: if (read_i && !store_event) state_d = RDY_IDLE;  // Fresh event stays
      default:  state_d = RDY_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state_q <= RDY_IDLE;
    else
      state_q <= state_d;
  end

  assign ready_o = (state_q == RDY_HOLD);
  assign event_o = event_q;

endmodule

//--- hw/ps2_keyboard.sv
// Receive-only PS/2 keyboard top; frame receiver feeding key decoder and ASCII table
`timescale 1ns/1ns

module ps2_keyboard
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk_i,
  input  logic       ps2_data_i,
  input  logic       read_i,          // Host acknowledge
  output key_event_t event_o,
  output logic       ready_o,         // Event waiting
  output logic       shift_key_on_o   // Live shift state
);

  ps2_frame_t frame;
  logic       frame_done;
  logic [7:0] scan_code;
  logic       shift_on;
  logic [7:0] ascii;

  ps2_rx_frame u_rx_frame (
    .clk          (clk),
    .reset        (reset),
    .ps2_clk_i    (ps2_clk_i),
    .ps2_data_i   (ps2_data_i),
    .frame_o      (frame),
    .frame_done_o (frame_done)
  );

  ps2_key_decode u_key_decode (
    .clk          (clk),
    .reset        (reset),
    .frame_i      (frame),
    .frame_done_i (frame_done),
    .read_i       (read_i),
    .ascii_i      (ascii),
    .scan_code_o  (scan_code),
    .shift_on_o   (shift_on),
    .event_o      (event_o),
    .ready_o      (ready_o)
  );

  // Combinational, closes the loop back into the decoder
  ps2_ascii_map u_ascii_map (
    .scan_code_i (scan_code),
    .shift_on_i  (shift_on),
    .ascii_o     (ascii)
  );

  assign shift_key_on_o = shift_on;

endmodule

//--- sim/tb_ps2_keyboard.sv
// Testbench for the PS/2 keyboard receiver; models a keyboard, reads events, checks by assertion
`timescale 1ns/1ns

module tb_ps2_keyboard
  import ps2_pkg::*;
;

  localparam int CLK_PERIOD     = 20;
  localparam int HALF_PERIOD    = 10;     // PS/2 clock half-period in clk cycles
  localparam int IDLE_GAP       = 40;     // Line idle between frames
  localparam int TIMEOUT_CYCLES = 40000;  // About 16 frames plus one watchdog idle, with margin

  logic       clk;
  logic       reset;
  logic       ps2_clk_i;
  logic       ps2_data_i;
  logic       read_i;
  key_event_t event_o;
  logic       ready_o;
  logic       shift_key_on_o;

  // Keyboard model state
  logic       release_pending;
  logic       left_shift;
  logic       right_shift;
  logic       expect_event;  // A key event is due or waiting
  key_event_t exp_event;
  int         sent_count;
  int         seen_count;
  int         cycle_count;
  string      test_name;

  // Event arrival detect
  logic       ready_q;
  key_event_t event_q;
  logic       event_new;

  ps2_keyboard u_dut (
    .clk            (clk),
    .reset          (reset),
    .ps2_clk_i      (ps2_clk_i),
    .ps2_data_i     (ps2_data_i),
    .read_i         (read_i),
    .event_o        (event_o),
    .ready_o        (ready_o),
    .shift_key_on_o (shift_key_on_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ------------------------------------------------------------
  // Failure reporting
  // ------------------------------------------------------------

  task automatic show_mismatch(input string what, input logic [17:0] expected,
                               input logic [17:0] actual);
    $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string why);
    $display("error in %s: %s", test_name, why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // ------------------------------------------------------------
  // Event monitor and assertions
  // ------------------------------------------------------------

  always @(posedge clk)
  begin
    if (reset)
    begin
      ready_q    <= 1'b0;
      event_q    <= '0;
      seen_count <= 0;
    end
    else
    begin
      ready_q <= ready_o;
      event_q <= event_o;
      if (event_new)
        seen_count <= seen_count + 1;  // Overwrites count too
    end
  end

  assign event_new = (ready_o && !ready_q) || (event_o != event_q);

  // Every stored event must be the one the model predicts
  assert property (@(posedge clk) disable iff (reset) event_new |-> (event_o == exp_event))
    else show_mismatch("event_o", exp_event, event_o);

  // No event for F0 or for a broken frame
  assert property (@(posedge clk) disable iff (reset) event_new |-> expect_event)
    else abort_run("an event appeared when no key code was sent");

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------------------------------------
  // Keyboard model and host tasks
  // ------------------------------------------------------------

  // Only the codes this test sends
  function automatic logic [7:0] expected_ascii(input logic [7:0] code, input logic shift);
    case (code)
      8'h1C:   expected_ascii = shift ? 8'h41 : 8'h61;  // a / A
      8'h16:   expected_ascii = 8'h31;
      8'h1E:   expected_ascii = 8'h32;
      8'h29:   expected_ascii = 8'h20;                  // Space
      default: expected_ascii = ASCII_UNKNOWN;
    endcase
  endfunction

  // Start, data LSB first, odd parity, stop; nbits below 11 cuts the frame short
  task automatic send_frame(input logic [7:0] code, input int nbits);
    logic [10:0] bits;
    bits = {1'b1, ~^code, code, 1'b0};
    for (int i = 0; i < nbits; i++)
    begin
      @(negedge clk);
      ps2_data_i = bits[0];
      bits = bits >> 1;
      repeat (HALF_PERIOD) @(negedge clk);
      ps2_clk_i = 1'b0;  // Keyboard clock falls mid-bit
      repeat (HALF_PERIOD) @(negedge clk);
      ps2_clk_i = 1'b1;
    end
    ps2_data_i = 1'b1;
    repeat (IDLE_GAP) @(negedge clk);
  endtask

  // Predict the event before the frame, since it lands before the frame ends
  task automatic send_key(input logic [7:0] code);
    logic shift_before;
    shift_before = left_shift | right_shift;
    if (code == SCAN_RELEASE)
      release_pending = 1'b1;
    else
    begin
      exp_event.released  = release_pending;
      exp_event.shift_on  = shift_before;
      exp_event.scan_code = code;
      exp_event.ascii     = expected_ascii(code, shift_before);
      if (code == SCAN_LEFT_SHIFT)
        left_shift = !release_pending;
      if (code == SCAN_RIGHT_SHIFT)
        right_shift = !release_pending;
      release_pending = 1'b0;
      expect_event    = 1'b1;
      sent_count      = sent_count + 1;
    end
    send_frame(code, FRAME_BITS);
    assert (shift_key_on_o == (left_shift | right_shift))
      else show_mismatch("shift_key_on_o", {17'd0, left_shift | right_shift},
                         {17'd0, shift_key_on_o});
  endtask

  // Wait for ready, let it sit for hold cycles, then take the event
  task automatic read_event(input int hold);
    while (!ready_o)
      @(negedge clk);
    repeat (hold)
    begin
      @(negedge clk);
      assert (ready_o) else abort_run("ready_o dropped before read_i");
    end
    assert (event_o == exp_event) else show_mismatch("read value", exp_event, event_o);
    assert (seen_count == sent_count) else abort_run("event count differs from keys sent");
    read_i = 1'b1;
    @(negedge clk);
    read_i = 1'b0;
    assert (!ready_o) else abort_run("ready_o stayed high after read_i");
    expect_event = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial
  begin
    reset           = 1'b1;
    ps2_clk_i       = 1'b1;  // Lines idle high
    ps2_data_i      = 1'b1;
    read_i          = 1'b0;
    release_pending = 1'b0;
    left_shift      = 1'b0;
    right_shift     = 1'b0;
    expect_event    = 1'b0;
    exp_event       = '0;
    sent_count      = 0;
    cycle_count     = 0;
    test_name       = "reset";
    repeat (5) @(negedge clk);
    reset = 1'b0;
    assert (!ready_o && !shift_key_on_o) else abort_run("outputs not cleared by reset");
    assert (event_o == '0) else show_mismatch("event_o", '0, event_o);

    test_name = "make code";
    send_key(8'h1C);
    read_event(20);

    test_name = "break sequence";
    send_key(SCAN_RELEASE);
    assert (!ready_o) else abort_run("ready_o rose for the F0 prefix");
    send_key(8'h1C);
    read_event(0);

    test_name = "left shift";
    send_key(SCAN_LEFT_SHIFT);
    read_event(0);
    send_key(8'h1C);  // Upper case
    read_event(0);
    send_key(SCAN_RELEASE);
    send_key(SCAN_LEFT_SHIFT);
    read_event(0);
    send_key(8'h1C);  // Back to lower case
    read_event(0);

    test_name = "right shift";
    send_key(SCAN_RIGHT_SHIFT);
    read_event(0);
    send_key(8'h1C);
    read_event(0);
    send_key(SCAN_RELEASE);
    send_key(SCAN_RIGHT_SHIFT);
    read_event(0);

    test_name = "overwrite";
    send_key(8'h16);
    send_key(8'h1E);  // Replaces 16 while unread
    assert (ready_o) else abort_run("ready_o fell without a read");
    read_event(0);

    test_name = "watchdog";
    send_frame(8'h1C, 4);
    repeat (RX_TIMEOUT_CYCLES + 50) @(negedge clk);
    assert (!ready_o) else abort_run("partial frame produced an event");
    send_key(8'h29);
    read_event(0);

    test_name = "unlisted code";
    send_key(8'h05);
    read_event(0);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- ps2_keyboard.f
common/ps2_pkg.sv
hw/ps2_rx_frame/ps2_rx_frame.sv
hw/ps2_ascii_map.sv
hw/ps2_key_decode.sv
hw/ps2_keyboard.sv
sim/tb_ps2_keyboard.sv

//--- Makefile
TB_TOP := tb_ps2_keyboard

.PHONY: simulate clean

simulate:
	verilator --binary --assert --timing -j 0 --top-module $(TB_TOP) -f ps2_keyboard.f
	out=$$(./obj_dir/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
